//--- cache_ctrl/beat_counter.sv
// ----------------------------
// Word beat counter for one line transfer on the memory port
// ----------------------------

module beat_counter (
  input  logic clk,
  input  logic reset,

  input  logic clear,
  input  logic step,

  output logic [1:0] beat,
  output logic last_beat
);

  // Wraps to zero after the last beat, so an eviction
  // hands a zeroed count straight to the refill
  always_ff @(posedge clk) begin
    if (reset) begin
      beat <= '0;
    end else if (clear) begin
      beat <= '0;
    end else if (step) begin
      beat <= beat + 2'd1;
    end
  end

  assign last_beat = (beat == 2'(cache_pkg::line_words - 1));

endmodule

//--- cache_ctrl/cache_ctrl.sv
// ----------------------------
// Cache FSM: tag check, hit access, dirty eviction and refill,
// with all four port handshakes decoded from the current state
// ----------------------------

module cache_ctrl (
  input  logic clk,
  input  logic reset,

  // Processor side
  input  logic cachereq_valid,
  output logic cachereq_ready,
  output logic cacheresp_valid,
  input  logic cacheresp_ready,

  // Memory side
  output logic memreq_valid,
  input  logic memreq_ready,
  input  logic memresp_valid,
  output logic memresp_ready,

  // Status from the datapath and beat counter
  input  cache_pkg::mem_op_t req_op,
  input  logic tag_hit,
  input  logic line_dirty,
  input  logic last_beat,

  // Datapath and beat counter controls
  output logic req_load,
  output logic tag_wen,
  output logic data_wen,
  output logic data_sel,
  output logic set_valid,
  output logic set_dirty,
  output logic clear_dirty,
  output logic addr_sel,
  output logic beat_clear,
  output logic beat_step
);

  // One bit per control, in table column order
  typedef struct packed {
    logic req_ready;
    logic resp_valid;
    logic mreq_valid;
    logic mresp_ready;
    logic req_load;
    logic tag_wen;
    logic data_wen;
    logic data_sel;
    logic set_valid;
    logic set_dirty;
    logic clear_dirty;
    logic addr_sel;
    logic beat_clear;
    logic beat_step;
  } ctrl_t;

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t state_next;
  ctrl_t ctrl;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::idle;
    end else begin
      state <= state_next;
    end
  end

  // ----------------------------
  // Next state
  // ----------------------------

  always_comb begin
    state_next = state;
    case (state)
      cache_pkg::idle: begin
        if (cachereq_valid) begin
          state_next = cache_pkg::tag_check;
        end
      end
      cache_pkg::tag_check: begin
        if (tag_hit) begin
          if (req_op == cache_pkg::op_write) begin
            state_next = cache_pkg::write_access;
          end else begin
            state_next = cache_pkg::read_access;
          end
        end else if (line_dirty) begin
          state_next = cache_pkg::evict_req;
        end else begin
          state_next = cache_pkg::refill_req;
        end
      end
      cache_pkg::read_access, cache_pkg::resp_wait: begin
        state_next = cacheresp_ready ? cache_pkg::idle : cache_pkg::resp_wait;
      end
      // Response goes out one cycle after the array write
      cache_pkg::write_access: state_next = cache_pkg::resp_wait;
      cache_pkg::evict_req: begin
        if (memreq_ready) begin
          state_next = cache_pkg::evict_wait;
        end
      end
      // Writes get no response, so the wait is a single cycle
      cache_pkg::evict_wait: begin
        state_next = last_beat ? cache_pkg::refill_req : cache_pkg::evict_req;
      end
      cache_pkg::refill_req: begin
        if (memreq_ready) begin
          state_next = cache_pkg::refill_wait;
        end
      end
      cache_pkg::refill_wait: begin
        if (memresp_valid) begin
          state_next = last_beat ? cache_pkg::refill_update : cache_pkg::refill_req;
        end
      end
      // Line is now present, so replay the access as a hit
      cache_pkg::refill_update: begin
        if (req_op == cache_pkg::op_write) begin
          state_next = cache_pkg::write_access;
        end else begin
          state_next = cache_pkg::read_access;
        end
      end
      default: state_next = cache_pkg::idle;
    endcase
  end

  // ----------------------------
  // Control table
  // ----------------------------

  // data_sel: 0 request word, 1 refill word
  // addr_sel: 0 evict address, 1 refill address
  always_comb begin
    case (state)
      //                            req rsp mrq mrs ld  tag dat dsl sv  sd  cd  asl bcl bst
      cache_pkg::idle:          ctrl = '{'1, '0, '0, '0, '1, '0, '0, '0, '0, '0, '0, '0, '0, '0};
      cache_pkg::tag_check:     ctrl = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '1, '0};
      cache_pkg::read_access:   ctrl = '{'0, '1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
      cache_pkg::write_access:  ctrl = '{'0, '0, '0, '0, '0, '0, '1, '0, '0, '1, '0, '0, '0, '0};
      cache_pkg::resp_wait:     ctrl = '{'0, '1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
      cache_pkg::evict_req:     ctrl = '{'0, '0, '1, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0};
      cache_pkg::evict_wait:    ctrl = '{'0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '0, '1};
      cache_pkg::refill_req:    ctrl = '{'0, '0, '1, '0, '0, '0, '0, '0, '0, '0, '0, '1, '0, '0};
      cache_pkg::refill_wait: begin
        ctrl = '{'0, '0, '0, '1, '0, '0, memresp_valid, '1, '0, '0, '0, '1, '0, memresp_valid};
      end
      cache_pkg::refill_update: ctrl = '{'0, '0, '0, '0, '0, '1, '0, '0, '1, '0, '1, '1, '0, '0};
      default:                  ctrl = '0;
    endcase
  end

  assign cachereq_ready  = ctrl.req_ready;
  assign cacheresp_valid = ctrl.resp_valid;
  assign memreq_valid    = ctrl.mreq_valid;
  assign memresp_ready   = ctrl.mresp_ready;
  assign req_load        = ctrl.req_load;
  assign tag_wen         = ctrl.tag_wen;
  assign data_wen        = ctrl.data_wen;
  assign data_sel        = ctrl.data_sel;
  assign set_valid       = ctrl.set_valid;
  assign set_dirty       = ctrl.set_dirty;
  assign clear_dirty     = ctrl.clear_dirty;
  assign addr_sel        = ctrl.addr_sel;
  assign beat_clear      = ctrl.beat_clear;
  assign beat_step       = ctrl.beat_step;

endmodule

//--- common/cache_pkg.sv
// ----------------------------
// Shared geometry, opcodes, FSM states and port payloads of the
// blocking cache, used by RTL and testbench by scoped names
// ----------------------------

package cache_pkg;

  // ----------------------------
  // Geometry
  // ----------------------------

  // Byte address and data word widths
  localparam int addr_bits = 12;
  localparam int word_bits = 32;

  // Direct-mapped, 8 lines of 4 words
  localparam int line_words = 4;
  localparam int num_lines = 8;

  // Address split is tag | index | byte offset
  localparam int index_bits = 3;
  localparam int offset_bits = 4;
  localparam int tag_bits = addr_bits - index_bits - offset_bits;

  // ----------------------------
  // Enums
  // ----------------------------

  // Opcode shared by the processor and memory ports
  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_t;

  // Controller states
  typedef enum logic [3:0] {
    idle,
    tag_check,
    read_access,
    write_access,
    resp_wait,
    evict_req,
    evict_wait,
    refill_req,
    refill_wait,
    refill_update
  } cache_state_t;

  // ----------------------------
  // Port payloads
  // ----------------------------

  typedef struct packed {
    mem_op_t op;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] data;
  } cache_req_t;

  typedef struct packed {
    mem_op_t op;
    logic [word_bits-1:0] data;
  } cache_resp_t;

  // Memory side, address always word-aligned
  typedef struct packed {
    mem_op_t op;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_op_t op;
    logic [word_bits-1:0] data;
  } mem_resp_t;

endpackage

//--- project.f
common/cache_pkg.sv
cache_ctrl/beat_counter.sv
cache_ctrl/cache_ctrl.sv
source/cache_dpath.sv
source/blocking_cache.sv
sim/cache_props.sv
sim/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module cache_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vcache_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
  echo "result: failed"
  exit 1
fi
if ! grep -q "PASS: all tests" "$log"; then
  echo "result: run ended without a verdict"
  exit 1
fi
echo "result: passed"
exit 0

//--- sim/cache_props.sv
// ----------------------------
// Bound checks for the blocking cache: response data against a shadow
// memory, blocking handshake, hold rules and memory beat order
// ----------------------------

module cache_props (
  input logic clk,
  input logic reset,
  input logic cachereq_valid,
  input logic cachereq_ready,
  input cache_pkg::cache_req_t cachereq,
  input logic cacheresp_valid,
  input logic cacheresp_ready,
  input cache_pkg::cache_resp_t cacheresp,
  input logic memreq_valid,
  input logic memreq_ready,
  input cache_pkg::mem_req_t memreq,
  input logic memresp_valid,
  input logic memresp_ready,
  input cache_pkg::cache_state_t state
);

  // Processor-visible value of every word
  logic [cache_pkg::word_bits-1:0] shadow [1024];

  cache_pkg::cache_req_t pend;
  logic busy;
  logic missed;
  logic rd_out;
  int unsigned lat;
  logic [1:0] mem_beat;
  logic [7:0] line_base;
  logic [7:0] mem_line;
  logic [7:0] pend_line;
  logic [cache_pkg::word_bits-1:0] exp_data;
  logic [cache_pkg::word_bits-1:0] evict_exp;

  int fail_count = 0;

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        shadow[i] <= {16'(i), 16'hc0de};
      end
      busy <= 1'b0;
      missed <= 1'b0;
      rd_out <= 1'b0;
      lat <= 0;
      mem_beat <= '0;
      line_base <= '0;
    end else begin
      if (cachereq_valid && cachereq_ready) begin
        busy <= 1'b1;
        missed <= 1'b0;
        lat <= 1;
        pend <= cachereq;
        if (cachereq.op == cache_pkg::op_write) begin
          shadow[cachereq.addr[11:2]] <= cachereq.data;
        end
      end else if (busy) begin
        lat <= lat + 1;
      end
      if (busy && memreq_valid) begin
        missed <= 1'b1;
      end
      if (cacheresp_valid && cacheresp_ready) begin
        busy <= 1'b0;
      end
      if (memreq_valid && memreq_ready) begin
        mem_beat <= mem_beat + 2'd1;
        line_base <= mem_line;
      end
      // A refill read is outstanding from its request until its response
      if (memreq_valid && memreq_ready && memreq.op == cache_pkg::op_read) begin
        rd_out <= 1'b1;
      end else if (memresp_valid && memresp_ready) begin
        rd_out <= 1'b0;
      end
    end
  end

  assign exp_data  = shadow[pend.addr[11:2]];
  assign evict_exp = shadow[memreq.addr[11:2]];
  assign mem_line  = memreq.addr[11:4];
  assign pend_line = pend.addr[11:4];

  // ----------------------------
  // Handshakes
  // ----------------------------

  a_reset_idle: assert property (@(posedge clk)
    reset |=> cachereq_ready && !cacheresp_valid && !memreq_valid && !memresp_ready)
  else begin
    fail_count++;
    $error("ports not idle during or after reset");
  end

  a_blocking: assert property (@(posedge clk) disable iff (reset)
    busy |-> !cachereq_ready)
  else begin
    fail_count++;
    $error("cachereq_ready raised while a request is outstanding");
  end

  a_no_spurious: assert property (@(posedge clk) disable iff (reset)
    cacheresp_valid |-> busy && lat >= 2)
  else begin
    fail_count++;
    $error("cacheresp_valid without a request or too early");
  end

  // Read hit answers in the second cycle after acceptance
  a_hit_latency: assert property (@(posedge clk) disable iff (reset)
    busy && pend.op == cache_pkg::op_read && !missed && !memreq_valid && lat == 2
      |-> cacheresp_valid)
  else begin
    fail_count++;
    $error("read hit response missing two cycles after acceptance");
  end

  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_valid && !cacheresp_ready |=> cacheresp_valid && $stable(cacheresp))
  else begin
    fail_count++;
    $error("cacheresp dropped or changed under back-pressure");
  end

  a_memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_valid && !memreq_ready |=> memreq_valid && $stable(memreq))
  else begin
    fail_count++;
    $error("memreq dropped or changed under back-pressure");
  end

  // Memory responses are taken only while a refill read waits
  a_memresp_ready: assert property (@(posedge clk) disable iff (reset)
    memresp_ready == rd_out)
  else begin
    fail_count++;
    $error("** Error memresp_ready: got %h expected %h", memresp_ready, rd_out);
  end

  // ----------------------------
  // Data and beat order
  // ----------------------------

  a_resp_op: assert property (@(posedge clk) disable iff (reset)
    cacheresp_valid |-> cacheresp.op == pend.op)
  else begin
    fail_count++;
    $error("** Error cacheresp.op: got %h expected %h", cacheresp.op, pend.op);
  end

  a_resp_data: assert property (@(posedge clk) disable iff (reset)
    cacheresp_valid && cacheresp_ready |-> cacheresp.data == exp_data)
  else begin
    fail_count++;
    $error("** Error cacheresp.data: got %h expected %h", cacheresp.data, exp_data);
  end

  a_evict_data: assert property (@(posedge clk) disable iff (reset)
    memreq_valid && memreq.op == cache_pkg::op_write |-> memreq.data == evict_exp)
  else begin
    fail_count++;
    $error("** Error memreq.data: got %h expected %h", memreq.data, evict_exp);
  end

  a_beat_order: assert property (@(posedge clk) disable iff (reset)
    memreq_valid |-> memreq.addr[3:0] == {mem_beat, 2'b00}
      && (mem_beat == 2'd0 || mem_line == line_base))
  else begin
    fail_count++;
    $error("** Error memreq.addr: got %h expected offset %h", memreq.addr,
      {mem_beat, 2'b00});
  end

  // Refill reads the missing line, eviction writes the other tag of the set
  a_mem_line: assert property (@(posedge clk) disable iff (reset)
    memreq_valid |-> (memreq.op == cache_pkg::op_read) ? mem_line == pend_line
      : (mem_line[2:0] == pend_line[2:0] && mem_line[7:3] != pend_line[7:3]))
  else begin
    fail_count++;
    $error("** Error memreq.addr: got %h for request %h", memreq.addr, pend.addr);
  end

  c_refill: cover property (@(posedge clk) state == cache_pkg::refill_update);
  c_evict: cover property (@(posedge clk) state == cache_pkg::evict_wait);

endmodule

bind blocking_cache cache_props u_props (
  .clk(clk),
  .reset(reset),
  .cachereq_valid(cachereq_valid),
  .cachereq_ready(cachereq_ready),
  .cachereq(cachereq),
  .cacheresp_valid(cacheresp_valid),
  .cacheresp_ready(cacheresp_ready),
  .cacheresp(cacheresp),
  .memreq_valid(memreq_valid),
  .memreq_ready(memreq_ready),
  .memreq(memreq),
  .memresp_valid(memresp_valid),
  .memresp_ready(memresp_ready),
  .state(u_ctrl.state)
);

//--- sim/cache_tb.sv
// ----------------------------
// Testbench for the blocking cache with a word memory model and
// random stalls. Checking is done by the bound assertions.
// ----------------------------

module cache_tb;

  logic clk = 1'b0;
  logic reset = 1'b1;

  logic cachereq_valid = 1'b0;
  logic cachereq_ready;
  cache_pkg::cache_req_t cachereq = '0;
  logic cacheresp_valid;
  logic cacheresp_ready = 1'b1;
  cache_pkg::cache_resp_t cacheresp;
  logic memreq_valid;
  logic memreq_ready = 1'b1;
  cache_pkg::mem_req_t memreq;
  logic memresp_valid = 1'b0;
  logic memresp_ready;
  cache_pkg::mem_resp_t memresp = '0;

  // Backing store, one entry per word address
  logic [cache_pkg::word_bits-1:0] mem [1024];
  logic rd_pending = 1'b0;
  logic [1:0] rd_wait = '0;
  logic [9:0] rd_word = '0;

  int completed = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int fails_before = 0;

  blocking_cache dut (.*);

  initial begin
    forever #10 clk = ~clk;
  end

  // ----------------------------
  // Memory model
  // ----------------------------

  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= {16'(i), 16'hc0de};
      end
      rd_pending <= 1'b0;
      memresp_valid <= 1'b0;
      memreq_ready <= 1'b1;
      cacheresp_ready <= 1'b1;
    end else begin
      // Random stalls on both ready inputs
      memreq_ready <= ($urandom % 4) != 0;
      cacheresp_ready <= ($urandom % 3) != 0;
      if (memresp_valid && memresp_ready) begin
        memresp_valid <= 1'b0;
      end
      if (memreq_valid && memreq_ready) begin
        if (memreq.op == cache_pkg::op_write) begin
          mem[memreq.addr[11:2]] <= memreq.data;
        end else begin
          rd_pending <= 1'b1;
          rd_word <= memreq.addr[11:2];
          rd_wait <= 2'($urandom % 4);
        end
      end else if (rd_pending) begin
        if (rd_wait == 2'd0) begin
          rd_pending <= 1'b0;
          memresp_valid <= 1'b1;
          memresp <= '{cache_pkg::op_read, mem[rd_word]};
        end else begin
          rd_wait <= rd_wait - 2'd1;
        end
      end
    end
  end

  // ----------------------------
  // Helpers
  // ----------------------------

  // One request, returns on the edge of its response transfer
  task automatic access(input cache_pkg::mem_op_t op, input logic [11:0] addr,
                        input logic [31:0] data);
    cachereq_valid <= 1'b1;
    cachereq <= '{op, addr, data};
    @(posedge clk);
    while (!cachereq_ready) begin
      @(posedge clk);
    end
    cachereq_valid <= 1'b0;
    @(posedge clk);
    while (!(cacheresp_valid && cacheresp_ready)) begin
      @(posedge clk);
    end
    completed++;
  endtask

  task automatic finish_test(input string name);
    int fails;
    fails = dut.u_props.fail_count - fails_before;
    tests_run++;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d assertion failures", name, fails);
    end
    fails_before = dut.u_props.fail_count;
  endtask

  // ----------------------------
  // Tests
  // ----------------------------

  initial begin
    void'($urandom(32'h240f));
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);
    finish_test("reset_idle");

    // First word of each line misses, the rest hit
    for (int line = 0; line < 4; line++) begin
      for (int w = 0; w < 4; w++) begin
        access(cache_pkg::op_read, 12'(16 * line + 4 * w), '0);
      end
    end
    finish_test("clean_read");

    access(cache_pkg::op_write, 12'h014, 32'ha5a5_0014);
    access(cache_pkg::op_read, 12'h014, '0);
    access(cache_pkg::op_write, 12'h058, 32'h5a5a_0058);
    access(cache_pkg::op_read, 12'h058, '0);
    access(cache_pkg::op_read, 12'h050, '0);
    finish_test("write_read");

    // Set 5 holds a dirty line from the previous test
    access(cache_pkg::op_read, 12'h0d0, '0);
    access(cache_pkg::op_read, 12'h058, '0);
    access(cache_pkg::op_write, 12'h0d4, 32'h0bad_00d4);
    access(cache_pkg::op_write, 12'h1d4, 32'h0bad_01d4);
    access(cache_pkg::op_read, 12'h0d4, '0);
    access(cache_pkg::op_read, 12'h1d4, '0);
    finish_test("dirty_evict");

    // Eight tags over all sets gives frequent conflicts
    for (int n = 0; n < 64; n++) begin
      access((($urandom % 2) != 0) ? cache_pkg::op_write : cache_pkg::op_read,
             12'(($urandom % 256) * 4), $urandom);
    end
    finish_test("random_mix");

    $display("tests run %0d, failed %0d, requests %0d, assertion failures %0d",
             tests_run, tests_failed, completed, dut.u_props.fail_count);
    if (tests_failed == 0 && dut.u_props.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Budget of 400 cycles per request, reset included
  initial begin
    int cycles;
    cycles = 0;
    while (cycles < 16 + 400 * (completed + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog: no response after %0d cycles, run stopped", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- source/blocking_cache.sv
// ----------------------------
// Blocking write-back cache top: FSM, beat counter and datapath
// between the processor port and the word-wide memory port
// ----------------------------

module blocking_cache (
  input  logic clk,
  input  logic reset,

  input  logic cachereq_valid,
  output logic cachereq_ready,
  input  cache_pkg::cache_req_t cachereq,

  output logic cacheresp_valid,
  input  logic cacheresp_ready,
  output cache_pkg::cache_resp_t cacheresp,

  output logic memreq_valid,
  input  logic memreq_ready,
  output cache_pkg::mem_req_t memreq,

  input  logic memresp_valid,
  output logic memresp_ready,
  input  cache_pkg::mem_resp_t memresp
);

  cache_pkg::mem_op_t req_op;
  logic tag_hit;
  logic line_dirty;
  logic last_beat;
  logic [1:0] beat;

  // FSM to datapath and counter
  logic req_load;
  logic tag_wen;
  logic data_wen;
  logic data_sel;
  logic set_valid;
  logic set_dirty;
  logic clear_dirty;
  logic addr_sel;
  logic beat_clear;
  logic beat_step;

  cache_ctrl u_ctrl (
    .clk(clk), .reset(reset),
    .cachereq_valid(cachereq_valid), .cachereq_ready(cachereq_ready),
    .cacheresp_valid(cacheresp_valid), .cacheresp_ready(cacheresp_ready),
    .memreq_valid(memreq_valid), .memreq_ready(memreq_ready),
    .memresp_valid(memresp_valid), .memresp_ready(memresp_ready),
    .req_op(req_op), .tag_hit(tag_hit), .line_dirty(line_dirty), .last_beat(last_beat),
    .req_load(req_load), .tag_wen(tag_wen), .data_wen(data_wen), .data_sel(data_sel),
    .set_valid(set_valid), .set_dirty(set_dirty), .clear_dirty(clear_dirty),
    .addr_sel(addr_sel), .beat_clear(beat_clear), .beat_step(beat_step)
  );

  beat_counter u_beat (
    .clk(clk), .reset(reset),
    .clear(beat_clear), .step(beat_step),
    .beat(beat), .last_beat(last_beat)
  );

  cache_dpath u_dpath (
    .clk(clk), .reset(reset),
    .cachereq(cachereq),
    .req_load(req_load), .tag_wen(tag_wen), .data_wen(data_wen), .data_sel(data_sel),
    .set_valid(set_valid), .set_dirty(set_dirty), .clear_dirty(clear_dirty),
    .addr_sel(addr_sel),
    .beat(beat), .memresp(memresp),
    .req_op(req_op), .tag_hit(tag_hit), .line_dirty(line_dirty),
    .cacheresp(cacheresp), .memreq(memreq)
  );

endmodule

//--- source/cache_dpath.sv
// ----------------------------
// Cache storage and datapath: request latch, tag/data arrays,
// valid and dirty bits, hit detection and memory request forming
// ----------------------------

module cache_dpath (
  input  logic clk,
  input  logic reset,

  input  cache_pkg::cache_req_t cachereq,

  // Controls from the FSM
  input  logic req_load,
  input  logic tag_wen,
  input  logic data_wen,
  input  logic data_sel,
  input  logic set_valid,
  input  logic set_dirty,
  input  logic clear_dirty,
  input  logic addr_sel,

  input  logic [1:0] beat,
  input  cache_pkg::mem_resp_t memresp,

  // Status back to the FSM
  output cache_pkg::mem_op_t req_op,
  output logic tag_hit,
  output logic line_dirty,

  output cache_pkg::cache_resp_t cacheresp,
  output cache_pkg::mem_req_t memreq
);

  cache_pkg::cache_req_t req_reg;

  logic [cache_pkg::tag_bits-1:0] req_tag;
  logic [cache_pkg::index_bits-1:0] req_index;
  logic [1:0] req_word;

  // Storage
  logic [cache_pkg::tag_bits-1:0] tag_array [cache_pkg::num_lines];
  logic [cache_pkg::word_bits-1:0] data_array [cache_pkg::num_lines][cache_pkg::line_words];
  logic [cache_pkg::num_lines-1:0] valid_bits;
  logic [cache_pkg::num_lines-1:0] dirty_bits;

  logic [1:0] wr_word;
  logic [cache_pkg::word_bits-1:0] wr_data;
  logic [cache_pkg::tag_bits-1:0] mem_tag;

  // ----------------------------
  // Request latch
  // ----------------------------

  always_ff @(posedge clk) begin
    if (req_load) begin
      req_reg <= cachereq;
    end
  end

  assign req_tag   = req_reg.addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];
  assign req_index = req_reg.addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign req_word  = req_reg.addr[cache_pkg::offset_bits-1:2];
  assign req_op    = req_reg.op;

  // ----------------------------
  // Arrays
  // ----------------------------

  always_ff @(posedge clk) begin
    if (tag_wen) begin
      tag_array[req_index] <= req_tag;
    end
  end

  // Refill fills by beat, a write hit by request offset
  assign wr_word = data_sel ? beat : req_word;
  assign wr_data = data_sel ? memresp.data : req_reg.data;

  always_ff @(posedge clk) begin
    if (data_wen) begin
      data_array[req_index][wr_word] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (set_valid) begin
        valid_bits[req_index] <= 1'b1;
      end
      if (set_dirty) begin
        dirty_bits[req_index] <= 1'b1;
      end else if (clear_dirty) begin
        dirty_bits[req_index] <= 1'b0;
      end
    end
  end

  assign tag_hit    = valid_bits[req_index] && (tag_array[req_index] == req_tag);
  assign line_dirty = valid_bits[req_index] && dirty_bits[req_index];

  // ----------------------------
  // Port payloads
  // ----------------------------

  assign cacheresp.op   = req_reg.op;
  assign cacheresp.data = data_array[req_index][req_word];

  // Eviction goes to the stored tag, refill to the requested one
  assign mem_tag = addr_sel ? req_tag : tag_array[req_index];

  always_comb begin
    if (addr_sel) begin
      memreq.op = cache_pkg::op_read;
    end else begin
      memreq.op = cache_pkg::op_write;
    end
    memreq.addr = {mem_tag, req_index, beat, 2'b00};
    memreq.data = data_array[req_index][beat];
  end

endmodule
